/* l1Pkg.sv */
// shared cache geometry, core/memory opcodes, status codes and sequencer states for the L1 subsystem
package l1Pkg;

	// cache geometry, both caches use the same shape
	localparam int lineCount = 16;		// lines per cache
	localparam int offsetBits = 4;		// byte offset in a 128-bit line
	localparam int indexBits = 4;		// line select
	localparam int tagBits = 24;		// upper address bits kept per line

	// low field of the exception word on a memory fault
	localparam logic [15:0] faultCode = 16'h8000;

	// core-side data cache operation
	typedef enum logic [1:0]
	{
		reqNone = 2'b00,		// no access this cycle
		reqLoad = 2'b01,		// 64-bit load
		reqStore = 2'b10		// 64-bit store, always written through
	} reqOpT;

	// memory-side operation, held non-idle until okReady or okFault
	typedef enum logic [1:0]
	{
		memNone = 2'b00,		// port idle
		memReadLine = 2'b01,	// fetch one 128-bit line
		memWriteWord = 2'b10	// write one 64-bit word in its line half
	} memOpT;

	// status on both core and memory sides
	typedef enum logic [1:0]
	{
		okReady = 2'b00,		// done, or idle
		okHold = 2'b10,			// busy, keep request steady
		okFault = 2'b11			// ends the access, nothing filled
	} memStatusT;

	// instruction cache sequencer
	typedef enum logic
	{
		icIdle = 1'b0,			// lookup each cycle
		icFill = 1'b1			// line read outstanding
	} icStateT;

	// data cache sequencer
	typedef enum logic [1:0]
	{
		dcIdle = 2'b00,			// lookup each cycle
		dcFill = 2'b01,			// load miss, line read outstanding
		dcWrite = 2'b10			// write-through outstanding
	} dcStateT;

	// a store hit merges into the line only when the write-through succeeds,
	// so cache and memory never disagree after a faulting store

endpackage

/* l1Icache.sv */
// direct-mapped instruction cache, one 64-bit fetch per cycle on hit, line refill through the arbiter
`timescale 1ns/1ps

module l1Icache
	import l1Pkg::*;
(
	input logic clock,
	input logic rstN,
	input logic [31:0] pcAddr,			// fetch address
	input logic pcHold,					// core back-pressure
	output logic [63:0] pcData,			// fetched word
	output memStatusT pcStatus,			// result status
	output logic [31:0] icMemAddr,		// line address toward arbiter
	output memOpT icMemOp,
	input logic [127:0] icMemData,		// refill line
	input memStatusT icMemStatus
);

	logic [127:0] lineData [lineCount];		// line storage
	logic [tagBits-1:0] lineTag [lineCount];
	logic [lineCount-1:0] lineValid;

	icStateT state;
	logic replay;						// re-run the missed fetch after refill
	logic [31:0] heldAddr;				// address of last accepted fetch

	logic [31:0] lookAddr;
	logic [indexBits-1:0] lookIndex;
	logic [tagBits-1:0] lookTag;
	logic lookHit;
	logic [63:0] lookWord;
	logic [indexBits-1:0] heldIndex;
	logic accept;
	logic fillDone;

	// lookup path, replay overrides the core address
	assign lookAddr = replay ? heldAddr : pcAddr;
	assign lookIndex = lookAddr[offsetBits +: indexBits];
	assign lookTag = lookAddr[offsetBits + indexBits +: tagBits];
	assign lookHit = lineValid[lookIndex] && (lineTag[lookIndex] == lookTag);
	assign lookWord = lookAddr[offsetBits - 1] ? lineData[lookIndex][127:64] :
		lineData[lookIndex][63:0];		// pick line half

	assign heldIndex = heldAddr[offsetBits +: indexBits];
	assign accept = (state == icIdle) && !pcHold;		// hold freezes the stage
	assign fillDone = (state == icFill) && (icMemStatus == okReady);

	// request port, line aligned
	assign icMemAddr = {heldAddr[offsetBits +: tagBits + indexBits], {offsetBits{1'b0}}};
	assign icMemOp = (state == icFill) ? memReadLine : memNone;

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			state <= icIdle;
			replay <= 1'b0;
			lineValid <= '0;				// all lines empty
			pcStatus <= okReady;
		end
		else
		begin
			case (state)
				icIdle:
				begin
					if (accept)
					begin
						replay <= 1'b0;
						if (lookHit)
							pcStatus <= okReady;
						else
						begin
							pcStatus <= okHold;		// miss, go refill
							state <= icFill;
						end
					end
				end
				icFill:
				begin
					if (icMemStatus == okReady)
					begin
						lineValid[heldIndex] <= 1'b1;
						replay <= 1'b1;				// status stays hold until replay hits
						state <= icIdle;
					end
					else if (icMemStatus == okFault)
					begin
						pcStatus <= okFault;		// line left invalid
						state <= icIdle;
					end
				end
				default:
					state <= icIdle;
			endcase
		end
	end

	// payload, no reset
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			heldAddr <= lookAddr;
			if (lookHit)
				pcData <= lookWord;
		end
		if (fillDone)
		begin
			lineData[heldIndex] <= icMemData;
			lineTag[heldIndex] <= heldAddr[offsetBits + indexBits +: tagBits];
		end
	end

endmodule

/* l1Dcache.sv */
// direct-mapped write-through data cache, 64-bit loads and stores, no allocate on store miss
`timescale 1ns/1ps

module l1Dcache
	import l1Pkg::*;
(
	input logic clock,
	input logic rstN,
	input logic [31:0] dcAddr,			// access address
	input reqOpT dcOp,
	input logic [63:0] dcWriteData,		// store data
	output logic [63:0] dcReadData,		// load result
	output memStatusT dcStatus,
	input logic dcHold,					// core back-pressure
	output logic [31:0] dcMemAddr,		// toward arbiter
	output memOpT dcMemOp,
	output logic [127:0] dcMemWriteData,
	input logic [127:0] dcMemData,		// refill line
	input memStatusT dcMemStatus
);

	logic [127:0] lineData [lineCount];
	logic [tagBits-1:0] lineTag [lineCount];
	logic [lineCount-1:0] lineValid;

	dcStateT state;
	logic replay;						// re-run a load after its refill
	logic [31:0] heldAddr;
	logic [63:0] heldData;				// store word in flight
	logic heldHit;						// store hit, merge on completion

	logic [31:0] lookAddr;
	reqOpT lookOp;
	logic [indexBits-1:0] lookIndex;
	logic [tagBits-1:0] lookTag;
	logic lookHit;
	logic [63:0] lookWord;
	logic [indexBits-1:0] heldIndex;
	logic accept;
	logic fillDone;
	logic writeDone;

	assign lookAddr = replay ? heldAddr : dcAddr;
	assign lookOp = replay ? reqLoad : dcOp;		// replay is always a load
	assign lookIndex = lookAddr[offsetBits +: indexBits];
	assign lookTag = lookAddr[offsetBits + indexBits +: tagBits];
	assign lookHit = lineValid[lookIndex] && (lineTag[lookIndex] == lookTag);
	assign lookWord = lookAddr[offsetBits - 1] ? lineData[lookIndex][127:64] :
		lineData[lookIndex][63:0];

	assign heldIndex = heldAddr[offsetBits +: indexBits];
	assign accept = (state == dcIdle) && !dcHold;
	assign fillDone = (state == dcFill) && (dcMemStatus == okReady);
	assign writeDone = (state == dcWrite) && (dcMemStatus == okReady);

	// line aligned for refill, word aligned for write-through
	assign dcMemAddr = (state == dcWrite) ?
		{heldAddr[31:offsetBits - 1], {(offsetBits - 1){1'b0}}} :
		{heldAddr[31:offsetBits], {offsetBits{1'b0}}};
	assign dcMemWriteData = heldAddr[offsetBits - 1] ? {heldData, 64'h0} : {64'h0, heldData};

	always_comb
	begin
		case (state)
			dcFill: dcMemOp = memReadLine;
			dcWrite: dcMemOp = memWriteWord;
			default: dcMemOp = memNone;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			state <= dcIdle;
			replay <= 1'b0;
			lineValid <= '0;
			dcStatus <= okReady;
		end
		else
		begin
			case (state)
				dcIdle:
				begin
					if (accept)
					begin
						replay <= 1'b0;
						case (lookOp)
							reqLoad:
							begin
								if (lookHit)
									dcStatus <= okReady;
								else
								begin
									dcStatus <= okHold;		// load miss
									state <= dcFill;
								end
							end
							reqStore:
							begin
								dcStatus <= okHold;			// every store goes out
								state <= dcWrite;
							end
							default:
								dcStatus <= okReady;		// idle cycle
						endcase
					end
				end
				dcFill:
				begin
					if (dcMemStatus == okReady)
					begin
						lineValid[heldIndex] <= 1'b1;
						replay <= 1'b1;
						state <= dcIdle;
					end
					else if (dcMemStatus == okFault)
					begin
						dcStatus <= okFault;
						state <= dcIdle;
					end
				end
				dcWrite:
				begin
					if (dcMemStatus != okHold)
					begin
						dcStatus <= dcMemStatus;			// ready or fault ends the store
						state <= dcIdle;
					end
				end
				default:
					state <= dcIdle;
			endcase
		end
	end

	// payload, no reset
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			heldAddr <= lookAddr;
			heldData <= dcWriteData;
			heldHit <= lookHit;
			if ((lookOp == reqLoad) && lookHit)
				dcReadData <= lookWord;
		end
		if (fillDone)
		begin
			lineData[heldIndex] <= dcMemData;
			lineTag[heldIndex] <= heldAddr[offsetBits + indexBits +: tagBits];
		end
		else if (writeDone && heldHit)
		begin
			if (heldAddr[offsetBits - 1])
				lineData[heldIndex][127:64] <= heldData;		// merge upper half
			else
				lineData[heldIndex][63:0] <= heldData;
		end
	end

endmodule

/* l1MemArbiter.sv */
// shares the external line port between the two caches, icache first, and registers the fault word
`timescale 1ns/1ps

module l1MemArbiter
	import l1Pkg::*;
(
	input logic clock,
	input logic rstN,
	input logic [31:0] icMemAddr,		// instruction cache request
	input memOpT icMemOp,
	output logic [127:0] icMemData,
	output memStatusT icMemStatus,
	input logic [31:0] dcMemAddr,		// data cache request
	input memOpT dcMemOp,
	input logic [127:0] dcMemWriteData,
	output logic [127:0] dcMemData,
	output memStatusT dcMemStatus,
	output logic [31:0] memAddr,		// external port
	output memOpT memOp,
	output logic [127:0] memWriteData,
	input logic [127:0] memReadData,
	input memStatusT memStatus,
	output logic [63:0] regOutExc		// fault word, one cycle late
);

	logic latchIc;						// grant held by icache
	logic latchDc;
	logic icActive;
	logic dcActive;
	logic icOwns;
	logic dcOwns;
	logic [63:0] excNext;

	assign icActive = (icMemOp != memNone);
	assign dcActive = (dcMemOp != memNone);
	assign icOwns = (icActive && !latchDc) || latchIc;		// wins a tie
	assign dcOwns = !icOwns && ((dcActive && !latchIc) || latchDc);

	// read data goes to both, status decides who uses it
	assign icMemData = memReadData;
	assign dcMemData = memReadData;

	always_comb
	begin
		memAddr = 32'h0;
		memOp = memNone;
		memWriteData = 128'h0;
		icMemStatus = icActive ? okHold : okReady;		// no grant, wait
		dcMemStatus = dcActive ? okHold : okReady;
		if (icOwns)
		begin
			memAddr = icMemAddr;
			memOp = icMemOp;
			icMemStatus = memStatus;
		end
		else if (dcOwns)
		begin
			memAddr = dcMemAddr;
			memOp = dcMemOp;
			memWriteData = dcMemWriteData;
			dcMemStatus = memStatus;
		end
		excNext = (memStatus == okFault) ? {16'h0, memAddr, faultCode} : 64'h0;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			latchIc <= 1'b0;
			latchDc <= 1'b0;
			regOutExc <= 64'h0;
		end
		else
		begin
			// keep grant until op drops and memory reports ready
			latchIc <= icOwns && (icActive || (memStatus != okReady));
			latchDc <= dcOwns && (dcActive || (memStatus != okReady));
			regOutExc <= excNext;
		end
	end

endmodule

/* memL1.sv */
// L1 memory subsystem top, instruction and data caches sharing one external line port
`timescale 1ns/1ps

module memL1
	import l1Pkg::*;
(
	input logic clock,
	input logic rstN,
	input logic [31:0] pcAddr,			// fetch side
	input logic pcHold,
	output logic [63:0] pcData,
	output memStatusT pcStatus,
	input logic [31:0] dcAddr,			// load/store side
	input reqOpT dcOp,
	input logic [63:0] dcWriteData,
	output logic [63:0] dcReadData,
	output memStatusT dcStatus,
	input logic dcHold,
	output logic [31:0] memAddr,		// external line memory
	output memOpT memOp,
	output logic [127:0] memWriteData,
	input logic [127:0] memReadData,
	input memStatusT memStatus,
	output logic [63:0] regOutExc
);

	logic [31:0] icMemAddr;				// icache to arbiter
	memOpT icMemOp;
	logic [127:0] icMemData;
	memStatusT icMemStatus;
	logic [31:0] dcMemAddr;				// dcache to arbiter
	memOpT dcMemOp;
	logic [127:0] dcMemWriteData;
	logic [127:0] dcMemData;
	memStatusT dcMemStatus;

	l1Icache u_icache (
		.clock(clock),
		.rstN(rstN),
		.pcAddr(pcAddr),
		.pcHold(pcHold),
		.pcData(pcData),
		.pcStatus(pcStatus),
		.icMemAddr(icMemAddr),
		.icMemOp(icMemOp),
		.icMemData(icMemData),
		.icMemStatus(icMemStatus)
	);

	l1Dcache u_dcache (
		.clock(clock),
		.rstN(rstN),
		.dcAddr(dcAddr),
		.dcOp(dcOp),
		.dcWriteData(dcWriteData),
		.dcReadData(dcReadData),
		.dcStatus(dcStatus),
		.dcHold(dcHold),
		.dcMemAddr(dcMemAddr),
		.dcMemOp(dcMemOp),
		.dcMemWriteData(dcMemWriteData),
		.dcMemData(dcMemData),
		.dcMemStatus(dcMemStatus)
	);

	l1MemArbiter u_arbiter (
		.clock(clock),
		.rstN(rstN),
		.icMemAddr(icMemAddr),
		.icMemOp(icMemOp),
		.icMemData(icMemData),
		.icMemStatus(icMemStatus),
		.dcMemAddr(dcMemAddr),
		.dcMemOp(dcMemOp),
		.dcMemWriteData(dcMemWriteData),
		.dcMemData(dcMemData),
		.dcMemStatus(dcMemStatus),
		.memAddr(memAddr),
		.memOp(memOp),
		.memWriteData(memWriteData),
		.memReadData(memReadData),
		.memStatus(memStatus),
		.regOutExc(regOutExc)
	);

endmodule

/* tbMemL1Tests.svh */
// directed tests for the L1 subsystem included inside the testbench module
`ifndef TB_MEM_L1_TESTS_SVH
`define TB_MEM_L1_TESTS_SVH

	// fetch until the status leaves hold and then freeze the icache on the result
	task automatic fetchWord(input logic [31:0] addr, output memStatusT status,
		output logic [63:0] data, output int cycles);
		pcAddr = addr;
		pcHold = 1'b0;
		cycles = 0;
		do
		begin
			nextCycle();
			cycles++;
		end
		while (pcStatus == okHold);
		pcHold = 1'b1;
		status = pcStatus;
		data = pcData;
	endtask

	// one load or store whose op is dropped once accepted
	task automatic dataAccess(input reqOpT op, input logic [31:0] addr, input logic [63:0] wdata,
		output memStatusT status, output logic [63:0] data, output int cycles);
		dcAddr = addr;
		dcOp = op;
		dcWriteData = wdata;
		cycles = 0;
		do
		begin
			nextCycle();
			cycles++;
			dcOp = reqNone;
		end
		while (dcStatus == okHold);
		status = dcStatus;
		data = dcReadData;
	endtask

	task automatic fetchMissThenHit();
		memStatusT st;
		logic [63:0] data;
		int cycles;
		fetchWord(32'h0000_1008, st, data, cycles);		// cold miss
		checkStatus("fetch miss status", okReady, st);
		checkData64("fetch miss data", patternWord(32'h0000_1008), data);
		fetchWord(32'h0000_1008, st, data, cycles);
		checkStatus("fetch hit status", okReady, st);
		checkCycles("fetch hit latency", 1, cycles);
		checkData64("fetch hit data", patternWord(32'h0000_1008), data);
		fetchWord(32'h0000_1000, st, data, cycles);		// low half of the same line
		checkStatus("fetch low half status", okReady, st);
		checkCycles("fetch low half latency", 1, cycles);
		checkData64("fetch low half data", patternWord(32'h0000_1000), data);
	endtask

	task automatic loadBothHalves();
		memStatusT st;
		logic [63:0] data;
		int cycles;
		dataAccess(reqLoad, 32'h0000_2000, '0, st, data, cycles);
		checkStatus("load miss status", okReady, st);
		checkData64("load miss data", patternWord(32'h0000_2000), data);
		dataAccess(reqLoad, 32'h0000_2008, '0, st, data, cycles);		// other half
		checkStatus("load hit status", okReady, st);
		checkCycles("load hit latency", 1, cycles);
		checkData64("load hit data", patternWord(32'h0000_2008), data);
	endtask

	task automatic storeHitAndMiss();
		memStatusT st;
		logic [63:0] data;
		int cycles;
		dataAccess(reqLoad, 32'h0000_3010, '0, st, data, cycles);		// bring line in
		dataAccess(reqStore, 32'h0000_3018, 64'h1122_3344_5566_7788, st, data, cycles);
		checkStatus("store hit status", okReady, st);
		checkData64("store hit memory", 64'h1122_3344_5566_7788, readWord(32'h0000_3018));
		dataAccess(reqLoad, 32'h0000_3018, '0, st, data, cycles);
		checkCycles("load after store hit latency", 1, cycles);
		checkData64("load after store hit", 64'h1122_3344_5566_7788, data);
		dataAccess(reqLoad, 32'h0000_3010, '0, st, data, cycles);		// untouched half
		checkData64("store hit other half", patternWord(32'h0000_3010), data);
		dataAccess(reqStore, 32'h0000_3400, 64'hCAFE_F00D_0BAD_BEEF, st, data, cycles);
		checkStatus("store miss status", okReady, st);
		checkData64("store miss memory", 64'hCAFE_F00D_0BAD_BEEF, readWord(32'h0000_3400));
		dataAccess(reqLoad, 32'h0000_3400, '0, st, data, cycles);		// refill sees the store
		checkData64("load after store miss", 64'hCAFE_F00D_0BAD_BEEF, data);
	endtask

	task automatic dualMissRace();
		pcAddr = 32'h0000_5028;
		pcHold = 1'b0;
		dcAddr = 32'h0000_6030;
		dcOp = reqLoad;
		nextCycle();
		dcOp = reqNone;
		fork
			begin
				while (pcStatus == okHold)
					nextCycle();
				pcHold = 1'b1;		// keep fetch result
			end
			begin
				while (dcStatus == okHold)
					nextCycle();
			end
		join
		checkStatus("dual fetch status", okReady, pcStatus);
		checkData64("dual fetch data", patternWord(32'h0000_5028), pcData);
		checkStatus("dual load status", okReady, dcStatus);
		checkData64("dual load data", patternWord(32'h0000_6030), dcReadData);
	endtask

	task automatic faultingAccess();
		memStatusT st;
		logic [63:0] data;
		int cycles;
		fetchWord(32'hF000_0100, st, data, cycles);
		checkStatus("fetch fault status", okFault, st);
		checkData64("fetch fault exception", {16'h0, 32'hF000_0100, faultCode}, regOutExc);
		nextCycle();
		checkData64("exception cleared after fetch", 64'h0, regOutExc);
		dataAccess(reqLoad, 32'hF123_4568, '0, st, data, cycles);		// reported line aligned
		checkStatus("load fault status", okFault, st);
		checkData64("load fault exception", {16'h0, 32'hF123_4560, faultCode}, regOutExc);
		nextCycle();
		checkData64("exception cleared after load", 64'h0, regOutExc);
	endtask

	task automatic heldLoadOutput();
		memStatusT st;
		logic [63:0] data;
		int cycles;
		dataAccess(reqLoad, 32'h0000_2008, '0, st, data, cycles);
		dcHold = 1'b1;
		dcAddr = 32'h0000_7000;		// new request must be ignored
		dcOp = reqLoad;
		repeat (3)
		begin
			nextCycle();
			checkData64("held load data", patternWord(32'h0000_2008), dcReadData);
			checkStatus("held load status", okReady, dcStatus);
		end
		dcOp = reqNone;
		dcHold = 1'b0;
		nextCycle();
	endtask

`endif

/* tbMemL1.sv */
// testbench for the L1 memory subsystem that drives both core ports and models the external line memory
`timescale 1ns/1ps

module tbMemL1
	import l1Pkg::*;
();

	localparam int timeoutCycles = 4000;		// about 60 accesses at 60 cycles worst case rounded up
	localparam logic [31:0] faultBase = 32'hF000_0000;		// model faults from here up

	logic clock;
	logic rstN;
	logic [31:0] pcAddr;
	logic pcHold;
	logic [63:0] pcData;
	memStatusT pcStatus;
	logic [31:0] dcAddr;
	reqOpT dcOp;
	logic [63:0] dcWriteData;
	logic [63:0] dcReadData;
	memStatusT dcStatus;
	logic dcHold;
	logic [31:0] memAddr;
	memOpT memOp;
	logic [127:0] memWriteData;
	logic [127:0] memReadData = '0;
	memStatusT memStatus;
	logic [63:0] regOutExc;

	logic [63:0] memWords [bit [31:0]];		// written words only
	logic [15:0] lfsrState = 16'd23337;
	logic respondNow = 1'b0;		// memory answers in this cycle
	logic faultNow = 1'b0;
	logic started = 1'b0;			// latency already drawn for this access
	int waitLeft = 0;
	int cycleCount;
	int dataErrors;
	int statusErrors;
	int otherErrors;

	memL1 u_memL1 (
		.clock(clock),
		.rstN(rstN),
		.pcAddr(pcAddr),
		.pcHold(pcHold),
		.pcData(pcData),
		.pcStatus(pcStatus),
		.dcAddr(dcAddr),
		.dcOp(dcOp),
		.dcWriteData(dcWriteData),
		.dcReadData(dcReadData),
		.dcStatus(dcStatus),
		.dcHold(dcHold),
		.memAddr(memAddr),
		.memOp(memOp),
		.memWriteData(memWriteData),
		.memReadData(memReadData),
		.memStatus(memStatus),
		.regOutExc(regOutExc)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;		// 100 ns period
	end

	// initial memory content is the word address XOR A5A5 pattern
	function automatic logic [63:0] patternWord(input logic [31:0] addr);
		logic [31:0] wordAddr;
		wordAddr = {addr[31:3], 3'b000};
		return {wordAddr, wordAddr} ^ 64'hA5A5_A5A5_A5A5_A5A5;
	endfunction

	function automatic logic [63:0] readWord(input logic [31:0] addr);
		logic [31:0] wordAddr;
		wordAddr = {addr[31:3], 3'b000};
		if (memWords.exists(wordAddr))
			return memWords[wordAddr];
		return patternWord(wordAddr);		// never written
	endfunction

	// fibonacci LFSR x^16+x^14+x^13+x^11 stepped once per latency bit
	function automatic int nextLatency();
		logic fb;
		int latency;
		latency = 0;
		for (int i = 0; i < 4; i++)
		begin
			fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
			lfsrState = {lfsrState[14:0], fb};
			latency = (latency << 1) | fb;
		end
		return latency;		// 0 to 15 extra cycles
	endfunction

	// status follows the op in the same cycle so a new request never sees a stale ready
	always_comb
	begin
		memStatus = okReady;		// idle port
		if (memOp != memNone)
		begin
			if (!respondNow)
				memStatus = okHold;
			else if (faultNow)
				memStatus = okFault;
		end
	end

	// line memory samples the port before the edge and answers 1 ns after it
	always @(posedge clock)
	begin
		memOpT opSeen;
		logic [31:0] addrSeen;
		logic [127:0] dataSeen;
		logic rstSeen;
		opSeen = memOp;
		addrSeen = memAddr;
		dataSeen = memWriteData;
		rstSeen = rstN;
		#1;
		if (!rstSeen)
		begin
			respondNow = 1'b0;
			started = 1'b0;
		end
		else if (respondNow)
		begin
			respondNow = 1'b0;		// requester took the answer at this edge
			started = 1'b0;
		end
		else if (opSeen != memNone)
		begin
			if (!started)
			begin
				started = 1'b1;
				waitLeft = nextLatency();
			end
			if (waitLeft > 0)
				waitLeft--;
			else
			begin
				respondNow = 1'b1;
				faultNow = (addrSeen >= faultBase);
				memReadData = faultNow ? '0 :
					{readWord({lineNumber(addrSeen), 4'h8}), readWord({lineNumber(addrSeen), 4'h0})};
				if ((opSeen == memWriteWord) && !faultNow)
					memWords[{addrSeen[31:3], 3'b000}] = addrSeen[3] ? dataSeen[127:64] :
						dataSeen[63:0];		// commits with the ready answer
			end
		end
	end

	function automatic logic [27:0] lineNumber(input logic [31:0] addr);
		return addr[31:4];		// line number
	endfunction

	task automatic nextCycle();
		@(posedge clock);
		#1;		// drive and sample clear of the edge
	endtask

	task automatic checkData64(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			dataErrors++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkStatus(input string name, input memStatusT expected,
		input memStatusT actual);
		if (actual !== expected)
		begin
			statusErrors++;
			$display("mismatch %s: expected %s, actual %s", name, expected.name(), actual.name());
		end
	endtask

	task automatic checkCycles(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			otherErrors++;
			$display("mismatch %s: expected %0d cycles, actual %0d", name, expected, actual);
		end
	endtask

	`include "tbMemL1Tests.svh"

	initial
	begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout after %0d cycles, an access never completed", cycleCount);
		$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		rstN = 1'b0;
		pcAddr = '0;
		pcHold = 1'b1;		// icache frozen between fetches
		dcAddr = '0;
		dcOp = reqNone;
		dcWriteData = '0;
		dcHold = 1'b0;
		dataErrors = 0;
		statusErrors = 0;
		otherErrors = 0;
		repeat (10) nextCycle();
		rstN = 1'b1;
		nextCycle();
		checkStatus("reset fetch status", okReady, pcStatus);
		checkStatus("reset data status", okReady, dcStatus);
		checkData64("reset exception", 64'h0, regOutExc);
		if (memOp != memNone)
		begin
			otherErrors++;
			$display("memory port is not idle after reset");
		end
		fetchMissThenHit();
		loadBothHalves();
		storeHitAndMiss();
		dualMissRace();
		faultingAccess();
		heldLoadOutput();
		$display("errors: %0d data, %0d status, %0d other", dataErrors, statusErrors, otherErrors);
		if (dataErrors + statusErrors + otherErrors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* sim.f */
+incdir+.
l1Pkg.sv
l1Icache.sv
l1Dcache.sv
l1MemArbiter.sv
memL1.sv
tbMemL1.sv

/* Bender.yml */
package:
  name: memL1

sources:
  - l1Pkg.sv
  - l1Icache.sv
  - l1Dcache.sv
  - l1MemArbiter.sv
  - memL1.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tbMemL1.sv
